// File: design/fhp_params.svh
// ==============================
// frame header parser constants
// format magic, word sizes, crc
// ==============================
`ifndef FHP_PARAMS_SVH
`define FHP_PARAMS_SVH

`define XP9_ID          32'h39505853
`define XP10_ID         32'h30315058
`define GZIP_ID1        8'h1F
`define GZIP_ID2        8'h8B
`define ZLIB_CM         4'h8

`define PFX_BASE_WORDS  10'd128
`define WORD_BYTES      4'd8

`define CRC_POLY        32'h04C11DB7
`define CRC_INIT        32'hFFFFFFFF

`define XP10_PFX_LSB    36
`define XP10_PFX_MSB    43

`endif

// File: design/tlv_pkg.sv
// ==============================
// tlv stream types
// input beat, header words, parse state
// ==============================
`default_nettype none

package tlv_pkg;

   typedef enum logic [7:0] {
      DATA  = 8'h0A,
      PFD   = 8'h0C,
      OTHER = 8'hFF
   } tlv_type_e;

   typedef enum logic [1:0] {
      PARSEABLE = 2'd0,
      RAW       = 2'd1
   } coding_e;

   typedef struct packed {
      logic [29:0] rsvd;
      coding_e     coding;
      logic        last_of_command;
      logic [7:0]  seq_num;
      logic [3:0]  eng_id;
      logic [10:0] frame_num;
      tlv_type_e   tlv_type;
   } data_word0_t;

   typedef struct packed {
      logic [52:0] rsvd;
      logic [1:0]  prefix_sel;
      logic        prefix_src;
      tlv_type_e   tlv_type;
   } pfd_word0_t;

   // sot word, read as either header
   typedef union packed {
      data_word0_t data;
      pfd_word0_t  pfd;
   } tlv_word0_u;

   typedef struct packed {
      logic        sot;
      logic        eot;
      logic [7:0]  tstrb;
      logic [63:0] tdata;
   } tlv_bus_t;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_PFD  = 2'd1,
      ST_DATA = 2'd2
   } parse_state_e;

   typedef struct packed {
      logic         valid;
      parse_state_e state;
      tlv_bus_t     tlv;
   } usr_beat_t;

endpackage

`default_nettype wire

// File: design/fhp_pkg.sv
// ==============================
// frame header parser outputs
// prefix, data path and sof records
// ==============================
`default_nettype none

package fhp_pkg;

   typedef enum logic [2:0] {
      NONE = 3'd0,
      XP9  = 3'd1,
      XP10 = 3'd2,
      GZIP = 3'd3,
      ZLIB = 3'd4
   } frm_fmt_e;

   typedef enum logic [1:0] {
      NO_ERRORS       = 2'd0,
      PFX_CRC         = 2'd1,
      PFX_DATA_ABSENT = 2'd2,
      BAD_FORMAT      = 2'd3
   } fhp_error_e;

   typedef struct packed {
      logic [63:0] data;
      logic        sof;
      logic        last;
   } prefix_bus_t;

   typedef struct packed {
      logic [63:0] data;
      logic        sof;
      logic        eof;
      logic [2:0]  bytes_valid;   // 0 means all 8
   } dp_bus_t;

   typedef struct packed {
      logic [27:0] frm_bytes;
      logic        last;
   } eof_bus_t;

   typedef struct packed {
      frm_fmt_e   sof_fmt;
      fhp_error_e error;
   } sof_bus_t;

   typedef struct packed {
      logic present;
      logic crc_error;
   } pfx_status_t;

endpackage

`default_nettype wire

// File: design/tlv_parser.sv
// ==============================
// tlv parser
// read strobe, type decode, beat register
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tlv_parser
   import tlv_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  tlv_bus_t  usr_tlv,
   input  logic      usr_empty,
   input  logic      prefix_ready,
   input  logic      dp_ready,
   output logic      usr_rd,
   output usr_beat_t beat
);

   tlv_word0_u   hdr;
   parse_state_e state;
   parse_state_e nxt_state;
   parse_state_e sot_state;
   logic         path_ready;
   logic         beat_valid;
   tlv_bus_t     beat_tlv;

   assign hdr = usr_tlv.tdata;

   always_comb begin
      case (state)
         ST_PFD:  path_ready = prefix_ready;
         ST_DATA: path_ready = dp_ready;
         default: path_ready = 1'b1;
      endcase
   end

   assign usr_rd = !usr_empty && path_ready;

   always_comb begin
      case (hdr.data.tlv_type)
         DATA:    sot_state = ST_DATA;
         PFD:     sot_state = ST_PFD;
         default: sot_state = ST_IDLE;   // other tlvs are dropped
      endcase
   end

   always_comb begin
      nxt_state = state;
      if (usr_rd && usr_tlv.sot) begin
         nxt_state = sot_state;
      end else if (beat_valid && beat_tlv.eot) begin
         nxt_state = ST_IDLE;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         beat_valid <= 1'b0;
      end else begin
         state      <= nxt_state;
         beat_valid <= usr_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (usr_rd) begin
         beat_tlv <= usr_tlv;
      end
   end

   // state already holds the word's own state
   assign beat = '{valid: beat_valid, state: state, tlv: beat_tlv};

endmodule

`default_nettype wire

// File: design/prefix_path.sv
// ==============================
// prefix path
// forwards prefix words, checks trailing crc
// ==============================
`timescale 1ns/1ps
`default_nettype none
`include "fhp_params.svh"

module prefix_path
   import tlv_pkg::*;
   import fhp_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  usr_beat_t   beat,
   input  logic        sof_valid,
   output logic        prefix_valid,
   output prefix_bus_t prefix_bus,
   output pfx_status_t pfx_status
);

   tlv_word0_u  hdr;
   logic        pfd_beat;
   logic        pfd_sot;
   logic        pfd_word;
   logic        pfd_eot;
   logic [9:0]  pfx_len;
   logic [9:0]  pfx_cnt;
   logic [31:0] crc;
   logic [31:0] crc_base;
   logic [31:0] crc_word;
   logic        got_crc;

   // msb-first shift, data bit 0 enters first
   function automatic logic [31:0] crc_fold(input logic [31:0] crc_in,
                                            input logic [63:0] data);
      logic [31:0] c;
      logic        fb;
      c = crc_in;
      for (int i = 0; i < 64; i++) begin
         fb = c[31] ^ data[i];
         c  = {c[30:0], 1'b0} ^ (fb ? `CRC_POLY : 32'h0);
      end
      return c;
   endfunction

   assign hdr      = beat.tlv.tdata;
   assign pfd_beat = beat.valid && (beat.state == ST_PFD);
   assign pfd_sot  = pfd_beat && beat.tlv.sot;
   assign pfd_word = pfd_beat && !beat.tlv.sot && !beat.tlv.eot && (pfx_cnt < pfx_len);
   assign pfd_eot  = pfd_beat && !beat.tlv.sot && beat.tlv.eot;
   assign crc_base = (pfx_cnt == '0) ? `CRC_INIT : crc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pfx_len      <= `PFX_BASE_WORDS;
         pfx_cnt      <= '0;
         prefix_valid <= 1'b0;
         prefix_bus   <= '0;
         got_crc      <= 1'b0;
         pfx_status   <= '0;
      end else begin
         prefix_valid <= pfd_word;
         got_crc      <= pfd_eot;
         if (pfd_sot) begin
            pfx_cnt <= '0;
            if (hdr.pfd.prefix_src) begin
               pfx_len <= (10'(hdr.pfd.prefix_sel) + 10'd1) * `PFX_BASE_WORDS;
            end else begin
               pfx_len <= `PFX_BASE_WORDS;
            end
         end else if (pfd_word) begin
            pfx_cnt    <= pfx_cnt + 10'd1;
            prefix_bus <= '{data: beat.tlv.tdata,
                            sof:  (pfx_cnt == '0),
                            last: (pfx_cnt == pfx_len - 10'd1)};
         end
         if (sof_valid) begin
            pfx_status.crc_error <= 1'b0;
         end
         if (got_crc && (crc_word != ~crc)) begin
            pfx_status.crc_error <= 1'b1;
         end
         // a new prefix wins over the old frame's clear
         if (pfd_sot) begin
            pfx_status.present <= 1'b1;
         end else if (sof_valid) begin
            pfx_status.present <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pfd_word) begin
         crc <= crc_fold(crc_base, beat.tlv.tdata);
      end
      if (pfd_eot) begin
         crc_word <= beat.tlv.tdata[31:0];
      end
   end

endmodule

`default_nettype wire

// File: design/data_path.sv
// ==============================
// data path
// forwards data beats, counts frame bytes
// ==============================
`timescale 1ns/1ps
`default_nettype none
`include "fhp_params.svh"

module data_path
   import tlv_pkg::*;
   import fhp_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  usr_beat_t beat,
   output logic      dp_valid,
   output dp_bus_t   dp_bus,
   output eof_bus_t  eof_bus
);

   tlv_word0_u  hdr;
   logic        dat_sot;
   logic        dat_word;
   logic        sof_armed;
   logic        last_cmd;
   logic [2:0]  bytes_valid;
   logic [3:0]  beat_bytes;
   logic [27:0] frm_bytes;

   assign hdr      = beat.tlv.tdata;
   assign dat_sot  = beat.valid && (beat.state == ST_DATA) && beat.tlv.sot;
   assign dat_word = beat.valid && (beat.state == ST_DATA) && !beat.tlv.sot;

   // full strobe wraps to 0
   assign bytes_valid = beat.tlv.eot ? 3'($countones(beat.tlv.tstrb)) : 3'd0;
   assign beat_bytes  = (bytes_valid == 3'd0) ? `WORD_BYTES : {1'b0, bytes_valid};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sof_armed <= 1'b0;
         last_cmd  <= 1'b0;
         frm_bytes <= '0;
         dp_valid  <= 1'b0;
         dp_bus    <= '0;
         eof_bus   <= '0;
      end else begin
         dp_valid <= dat_word;
         if (dat_sot) begin
            sof_armed <= 1'b1;
            last_cmd  <= hdr.data.last_of_command;
            frm_bytes <= '0;
         end else if (dat_word) begin
            sof_armed <= 1'b0;
            dp_bus    <= '{data:        beat.tlv.tdata,
                           sof:         sof_armed,
                           eof:         beat.tlv.eot,
                           bytes_valid: bytes_valid};
            if (beat.tlv.eot) begin
               eof_bus   <= '{frm_bytes: frm_bytes + 28'(beat_bytes), last: last_cmd};
               frm_bytes <= '0;
            end else begin
               eof_bus   <= '0;
               frm_bytes <= frm_bytes + 28'(beat_bytes);
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: design/sof_detect.sv
// ==============================
// start of frame detect
// format and error on first payload beat
// ==============================
`timescale 1ns/1ps
`default_nettype none
`include "fhp_params.svh"

module sof_detect
   import tlv_pkg::*;
   import fhp_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  usr_beat_t   beat,
   input  pfx_status_t pfx_status,
   output logic        sof_valid,
   output sof_bus_t    sof_bus
);

   tlv_word0_u  hdr;
   logic        dat_sot;
   logic        first_beat;
   logic        first_pend;
   coding_e     coding;
   logic [63:0] word;
   fhp_error_e  crc_err;
   frm_fmt_e    fmt;
   fhp_error_e  err;

   assign hdr        = beat.tlv.tdata;
   assign word       = beat.tlv.tdata;
   assign dat_sot    = beat.valid && (beat.state == ST_DATA) && beat.tlv.sot;
   assign first_beat = beat.valid && (beat.state == ST_DATA) && !beat.tlv.sot && first_pend;
   assign crc_err    = pfx_status.crc_error ? PFX_CRC : NO_ERRORS;

   always_comb begin
      fmt = NONE;
      err = NO_ERRORS;   // raw coding stays here
      if (coding == PARSEABLE) begin
         if (word[31:0] == `XP9_ID) begin
            fmt = XP9;
            err = crc_err;
         end else if (word[31:0] == `XP10_ID) begin
            fmt = XP10;
            if (pfx_status.crc_error) begin
               err = PFX_CRC;
            end else if (!pfx_status.present &&
                         (word[`XP10_PFX_MSB:`XP10_PFX_LSB] != '0)) begin
               err = PFX_DATA_ABSENT;
            end
         end else if ((word[7:0] == `GZIP_ID1) && (word[15:8] == `GZIP_ID2)) begin
            fmt = GZIP;
            err = crc_err;
         end else if (word[3:0] == `ZLIB_CM) begin
            fmt = ZLIB;
            err = crc_err;
         end else begin
            err = BAD_FORMAT;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         coding     <= PARSEABLE;
         first_pend <= 1'b0;
         sof_valid  <= 1'b0;
         sof_bus    <= '0;
      end else begin
         sof_valid <= first_beat;
         if (dat_sot) begin
            coding     <= hdr.data.coding;
            first_pend <= 1'b1;
         end else if (first_beat) begin
            first_pend <= 1'b0;
            sof_bus    <= '{sof_fmt: fmt, error: err};
         end
      end
   end

endmodule

`default_nettype wire

// File: design/fhp_top.sv
// ==============================
// frame header parser, user side
// parser feeding prefix, data and sof paths
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fhp_top
   import tlv_pkg::*;
   import fhp_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  tlv_bus_t    usr_tlv,
   input  logic        usr_empty,
   output logic        usr_rd,
   input  logic        prefix_ready,
   input  logic        dp_ready,
   output logic        prefix_valid,
   output prefix_bus_t prefix_bus,
   output logic        dp_valid,
   output dp_bus_t     dp_bus,
   output eof_bus_t    eof_bus,
   output logic        sof_valid,
   output sof_bus_t    sof_bus
);

   usr_beat_t   beat;
   pfx_status_t pfx_status;

   tlv_parser tlv_parser_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .usr_tlv      (usr_tlv),
      .usr_empty    (usr_empty),
      .prefix_ready (prefix_ready),
      .dp_ready     (dp_ready),
      .usr_rd       (usr_rd),
      .beat         (beat)
   );

   prefix_path prefix_path_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat         (beat),
      .sof_valid    (sof_valid),
      .prefix_valid (prefix_valid),
      .prefix_bus   (prefix_bus),
      .pfx_status   (pfx_status)
   );

   data_path data_path_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .beat     (beat),
      .dp_valid (dp_valid),
      .dp_bus   (dp_bus),
      .eof_bus  (eof_bus)
   );

   sof_detect sof_detect_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat       (beat),
      .pfx_status (pfx_status),
      .sof_valid  (sof_valid),
      .sof_bus    (sof_bus)
   );

endmodule

`default_nettype wire

// File: testbench/fhp_props.sv
// ==============================
// frame header parser properties
// fifo read, sof alignment, reset
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fhp_props
   import fhp_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input logic        usr_empty,
   input logic        usr_rd,
   input logic        prefix_valid,
   input prefix_bus_t prefix_bus,
   input logic        dp_valid,
   input dp_bus_t     dp_bus,
   input eof_bus_t    eof_bus,
   input logic        sof_valid,
   input sof_bus_t    sof_bus
);

   rd_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
      usr_empty |-> !usr_rd)
      else $error("usr_rd high while the fifo is empty");

   // sof record rides on the first data beat
   sof_on_dp_sof: assert property (@(posedge clk) disable iff (!rst_n)
      sof_valid |-> (dp_valid && dp_bus.sof))
      else $error("sof_valid without a dp sof beat");

   quiet_in_reset: assert property (@(posedge clk)
      !rst_n |-> (!usr_rd && !prefix_valid && !dp_valid && !sof_valid &&
                  prefix_bus == '0 && dp_bus == '0 && eof_bus == '0 && sof_bus == '0))
      else $error("outputs active during reset");

endmodule

bind fhp_top fhp_props fhp_props_inst (
   .clk          (clk),
   .rst_n        (rst_n),
   .usr_empty    (usr_empty),
   .usr_rd       (usr_rd),
   .prefix_valid (prefix_valid),
   .prefix_bus   (prefix_bus),
   .dp_valid     (dp_valid),
   .dp_bus       (dp_bus),
   .eof_bus      (eof_bus),
   .sof_valid    (sof_valid),
   .sof_bus      (sof_bus)
);

`default_nettype wire

// File: testbench/tb_fhp.sv
// ==============================
// frame header parser testbench
// fifo model, crc model, output checks
// ==============================
`timescale 1ns/1ps
`default_nettype none
`include "fhp_params.svh"

module tb_fhp
   import tlv_pkg::*;
   import fhp_pkg::*;
;

   // 4+12 frames, 130+3, 130+3+3, 3, 258+41
   localparam int TOTAL_BEATS  = 4 + 12 + 133 + 136 + 3 + 299;
   localparam int RUN_LIMIT_NS = TOTAL_BEATS * 4 * 20 + 16 * 20 + 2000;

   logic        clk;
   logic        rst_n;
   tlv_bus_t    usr_tlv;
   logic        usr_empty;
   logic        usr_rd;
   logic        prefix_ready;
   logic        dp_ready;
   logic        prefix_valid;
   prefix_bus_t prefix_bus;
   logic        dp_valid;
   dp_bus_t     dp_bus;
   eof_bus_t    eof_bus;
   logic        sof_valid;
   sof_bus_t    sof_bus;

   tlv_bus_t    fifo_q[$];
   prefix_bus_t exp_pfx[$];
   dp_bus_t     exp_dp[$];
   eof_bus_t    exp_eof[$];
   sof_bus_t    exp_sof[$];
   integer      seed;
   logic        took;
   logic        bp_on;
   logic [1:0]  pfx_rdy_hist;   // ready seen at the last two negedges
   logic [1:0]  dp_rdy_hist;
   int          errors;
   int          err_mark;
   int          n_tests;
   int          n_failed;

   fhp_top fhp_top_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .usr_tlv      (usr_tlv),
      .usr_empty    (usr_empty),
      .usr_rd       (usr_rd),
      .prefix_ready (prefix_ready),
      .dp_ready     (dp_ready),
      .prefix_valid (prefix_valid),
      .prefix_bus   (prefix_bus),
      .dp_valid     (dp_valid),
      .dp_bus       (dp_bus),
      .eof_bus      (eof_bus),
      .sof_valid    (sof_valid),
      .sof_bus      (sof_bus)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // reference crc32 with word bit 0 shifted in first
   function automatic logic [31:0] crc_update(input logic [31:0] crc_in, input logic [63:0] w);
      logic [31:0] r;
      r = crc_in;
      for (int b = 0; b < 64; b++) begin
         if (r[31] ^ w[b]) begin
            r = (r << 1) ^ `CRC_POLY;
         end else begin
            r = r << 1;
         end
      end
      return r;
   endfunction

   // fifo model popping what the dut read at the last edge
   always begin
      @(negedge clk);
      took = usr_rd;
      @(posedge clk);
      #2;
      if (took && fifo_q.size() != 0) begin
         void'(fifo_q.pop_front());
      end
      usr_empty = (fifo_q.size() == 0);
      usr_tlv   = usr_empty ? '0 : fifo_q[0];
      if (bp_on) begin
         prefix_ready = 1'($random(seed));
         dp_ready     = 1'($random(seed));
      end else begin
         prefix_ready = 1'b1;
         dp_ready     = 1'b1;
      end
   end

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
      assert (got === exp) else begin
         $display("ERROR %s expected %h got %h", name, exp, got);
         errors++;
      end
   endtask

   task automatic push_beat(input logic sot, input logic eot, input logic [7:0] strb,
                            input logic [63:0] data);
      tlv_bus_t b;
      b.sot   = sot;
      b.eot   = eot;
      b.tstrb = strb;
      b.tdata = data;
      fifo_q.push_back(b);
   endtask

   task automatic send_frame(input coding_e coding, input logic last_cmd,
                             input logic [63:0] first_word, input int n_beats,
                             input int last_bytes, input frm_fmt_e fmt, input fhp_error_e err);
      data_word0_t hdr;
      dp_bus_t     d;
      eof_bus_t    f;
      sof_bus_t    s;
      logic [63:0] w;
      logic        eot;
      hdr                 = '0;
      hdr.tlv_type        = DATA;
      hdr.coding          = coding;
      hdr.last_of_command = last_cmd;
      push_beat(1'b1, 1'b0, 8'hFF, hdr);
      for (int i = 0; i < n_beats; i++) begin
         w   = (i == 0) ? first_word : {$random(seed), $random(seed)};
         eot = (i == n_beats - 1);
         push_beat(1'b0, eot, eot ? 8'(8'hFF >> (8 - last_bytes)) : 8'hFF, w);
         d.data        = w;
         d.sof         = (i == 0);
         d.eof         = eot;
         d.bytes_valid = (eot && last_bytes != 8) ? 3'(last_bytes) : 3'd0;   // full word is 0
         exp_dp.push_back(d);
      end
      f.frm_bytes = 28'(8 * (n_beats - 1) + last_bytes);
      f.last      = last_cmd;
      exp_eof.push_back(f);
      s.sof_fmt = fmt;
      s.error   = err;
      exp_sof.push_back(s);
   endtask

   task automatic send_prefix(input logic src, input logic [1:0] sel, input logic bad_crc);
      pfd_word0_t  hdr;
      prefix_bus_t p;
      logic [63:0] w;
      logic [31:0] crc;
      int          n_words;
      hdr            = '0;
      hdr.tlv_type   = PFD;
      hdr.prefix_src = src;
      hdr.prefix_sel = sel;
      n_words = src ? (int'(sel) + 1) * int'(`PFX_BASE_WORDS) : int'(`PFX_BASE_WORDS);
      push_beat(1'b1, 1'b0, 8'hFF, hdr);
      crc = `CRC_INIT;
      for (int i = 0; i < n_words; i++) begin
         w   = {$random(seed), $random(seed)};
         crc = crc_update(crc, w);
         push_beat(1'b0, 1'b0, 8'hFF, w);
         p.data = w;
         p.sof  = (i == 0);
         p.last = (i == n_words - 1);
         exp_pfx.push_back(p);
      end
      w = {$random(seed), ~crc ^ (bad_crc ? 32'h0000_0001 : 32'h0)};
      push_beat(1'b0, 1'b1, 8'hFF, w);   // trailing crc word
   endtask

   task automatic check_pfx();
      prefix_bus_t e;
      // word was read two cycles back, in the PFD state
      assert (pfx_rdy_hist[1]) else begin
         $display("prefix word was read while prefix_ready was low");
         errors++;
      end
      assert (exp_pfx.size() != 0) else begin
         $display("prefix word arrived while none was expected");
         errors++;
      end
      if (exp_pfx.size() != 0) begin
         e = exp_pfx.pop_front();
         check_val("prefix_bus.data", e.data, prefix_bus.data);
         check_val("prefix_bus.sof", 64'(e.sof), 64'(prefix_bus.sof));
         check_val("prefix_bus.last", 64'(e.last), 64'(prefix_bus.last));
      end
   endtask

   task automatic check_dp();
      dp_bus_t  e;
      eof_bus_t f;
      assert (dp_rdy_hist[1]) else begin
         $display("data beat was read while dp_ready was low");
         errors++;
      end
      assert (exp_dp.size() != 0) else begin
         $display("data beat arrived while none was expected");
         errors++;
      end
      if (exp_dp.size() != 0) begin
         e = exp_dp.pop_front();
         check_val("dp_bus.data", e.data, dp_bus.data);
         check_val("dp_bus.sof", 64'(e.sof), 64'(dp_bus.sof));
         check_val("dp_bus.eof", 64'(e.eof), 64'(dp_bus.eof));
         check_val("dp_bus.bytes_valid", 64'(e.bytes_valid), 64'(dp_bus.bytes_valid));
         if (e.eof && exp_eof.size() != 0) begin
            f = exp_eof.pop_front();
            check_val("eof_bus.frm_bytes", 64'(f.frm_bytes), 64'(eof_bus.frm_bytes));
            check_val("eof_bus.last", 64'(f.last), 64'(eof_bus.last));
         end
      end
   endtask

   task automatic check_sof();
      sof_bus_t e;
      assert (exp_sof.size() != 0) else begin
         $display("start of frame record arrived while none was expected");
         errors++;
      end
      if (exp_sof.size() != 0) begin
         e = exp_sof.pop_front();
         check_val("sof_bus.sof_fmt", 64'(e.sof_fmt), 64'(sof_bus.sof_fmt));
         check_val("sof_bus.error", 64'(e.error), 64'(sof_bus.error));
      end
   endtask

   always @(negedge clk) begin
      if (rst_n && prefix_valid) check_pfx();
      if (rst_n && dp_valid) check_dp();
      if (rst_n && sof_valid) check_sof();
      pfx_rdy_hist = {pfx_rdy_hist[0], prefix_ready};
      dp_rdy_hist  = {dp_rdy_hist[0], dp_ready};
   end

   // waits until every queued word went in and every expected output came out
   task automatic end_test(input string name);
      while (fifo_q.size() != 0 || exp_pfx.size() != 0 || exp_dp.size() != 0 ||
             exp_eof.size() != 0 || exp_sof.size() != 0) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);
      n_tests++;
      if (errors != err_mark) n_failed++;
      $display("test %0d %s: %s", n_tests, name, (errors == err_mark) ? "ok" : "failed");
      err_mark = errors;
   endtask

   initial begin
      #(RUN_LIMIT_NS);
      $display("watchdog expired before the tests finished");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      rst_n        = 1'b1;
      usr_tlv      = '0;
      usr_empty    = 1'b1;
      prefix_ready = 1'b1;
      dp_ready     = 1'b1;
      bp_on        = 1'b0;
      took         = 1'b0;
      pfx_rdy_hist = 2'b11;
      dp_rdy_hist  = 2'b11;
      seed         = 65308;
      errors       = 0;
      err_mark     = 0;
      n_tests      = 0;
      n_failed     = 0;
      #1 rst_n = 1'b0;
      repeat (16) @(posedge clk);
      #2 rst_n = 1'b1;
      repeat (2) @(negedge clk);

      send_frame(PARSEABLE, 1'b1, 64'h0000_0000_0008_8B1F, 3, 5, GZIP, NO_ERRORS);
      end_test("gzip frame");

      send_frame(PARSEABLE, 1'b0, 64'h0000_0000_0000_9C78, 2, 8, ZLIB, NO_ERRORS);
      send_frame(PARSEABLE, 1'b1, 64'h0000_0000_3950_5853, 2, 3, XP9, NO_ERRORS);
      send_frame(RAW, 1'b0, 64'h0000_0000_0008_8B1F, 2, 1, NONE, NO_ERRORS);
      send_frame(PARSEABLE, 1'b0, 64'h1234_5678_9ABC_DEF0, 2, 7, NONE, BAD_FORMAT);
      end_test("other formats");

      send_prefix(1'b0, 2'd0, 1'b0);
      send_frame(PARSEABLE, 1'b1, 64'h0000_0AB0_3031_5058, 2, 4, XP10, NO_ERRORS);
      end_test("good prefix");

      send_prefix(1'b0, 2'd0, 1'b1);
      send_frame(PARSEABLE, 1'b0, 64'h0000_0AB0_3031_5058, 2, 6, XP10, PFX_CRC);
      send_frame(PARSEABLE, 1'b0, 64'h0000_0000_3031_5058, 2, 2, XP10, NO_ERRORS);
      end_test("bad prefix crc");

      send_frame(PARSEABLE, 1'b1, 64'h0000_0AB0_3031_5058, 2, 8, XP10, PFX_DATA_ABSENT);
      end_test("missing prefix");

      bp_on = 1'b1;
      send_prefix(1'b1, 2'd1, 1'b0);
      send_frame(PARSEABLE, 1'b1, 64'h0000_0AB0_3031_5058, 40, 8, XP10, NO_ERRORS);
      end_test("back-pressure");
      bp_on = 1'b0;

      $display("tests run %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/tlv_pkg.sv
design/fhp_pkg.sv
design/tlv_parser.sv
design/prefix_path.sv
design/data_path.sv
design/sof_detect.sv
design/fhp_top.sv
testbench/fhp_props.sv
testbench/tb_fhp.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the frame header parser testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_fhp -f sim.f -o tb_fhp || exit 1
{ ./obj_dir/tb_fhp || echo "** FAIL **"; } 2>&1 | tee sim.log
grep -q "\*\* FAIL \*\*" sim.log && echo "simulation failed" && exit 1 || echo "simulation passed"
